// ==== design/battle_text_pkg.sv ====
package battle_text_pkg;

   // pixel coordinate and character types
   typedef logic [9:0] coord_t;
   typedef logic [7:0] char_t;

   // 8x16 character cell
   localparam int cell_w = 8;
   localparam int cell_h = 16;
   typedef logic [2:0] glyph_col_t;
   typedef logic [3:0] glyph_row_t;

   // field numbering, 0 has the highest priority
   localparam int field_count = 6;
   typedef logic [2:0] field_id_t;
   localparam field_id_t fld_name     = 3'd0;
   localparam field_id_t fld_move     = 3'd1;
   localparam field_id_t fld_enemy    = 3'd2;
   localparam field_id_t fld_used     = 3'd3;
   localparam field_id_t fld_hp_label = 3'd4;
   localparam field_id_t fld_hp_value = 3'd5;

   // longest field is the move name
   localparam int max_chars = 12;
   typedef logic [3:0] char_index_t;

   // field lengths in characters
   localparam int name_len     = 9;
   localparam int move_len     = 12;
   localparam int enemy_len    = 6;
   localparam int used_len     = 5;
   localparam int hp_label_len = 2;
   localparam int hp_value_len = 7;

   // top left corner of each field
   localparam coord_t enemy_x    = 10'd32;
   localparam coord_t enemy_y    = 10'd16;
   localparam coord_t name_x     = 10'd80;
   localparam coord_t name_y     = 10'd16;
   localparam coord_t hp_label_x = 10'd32;
   localparam coord_t hp_label_y = 10'd48;
   localparam coord_t hp_value_x = 10'd56;
   localparam coord_t hp_value_y = 10'd48;
   localparam coord_t used_x     = 10'd32;
   localparam coord_t used_y     = 10'd400;
   localparam coord_t move_x     = 10'd72;
   localparam coord_t move_y     = 10'd400;

   // frame attributes
   typedef logic [2:0] poke_id_t;
   typedef logic [4:0] move_id_t;
   // hit points stay below 200
   typedef logic [7:0] hp_t;

   // ascii codes used by the formatting
   localparam char_t char_space = 8'h20;
   localparam char_t char_zero  = 8'h30;
   localparam char_t char_one   = 8'h31;
   localparam char_t char_slash = 8'h2F;

   // table sizes
   localparam int name_count = 8;
   localparam int move_count = 26;

   // creature names, space padded, character 0 leftmost
   localparam logic [0:name_len-1][7:0] name_table [name_count] = '{
      "BLASTOISE", "CHARIZARD", "DRAGONITE", "GENGAR   ",
      "MEW      ", "PIKACHU  ", "VENUSAUR ", "WEEZING  "
   };

   // move names, space padded
   localparam logic [0:move_len-1][7:0] move_table [move_count] = '{
      "HYDRO PUMP  ", "ICE BEAM    ", "CRUNCH      ", "AURA SPHERE ",
      "FLAMETHROWER", "THUNDERPUNCH", "AIR SLASH   ", "DRAGON CLAW ",
      "ENERGY BALL ", "SLUDGE BOMB ", "EARTHQUAKE  ", "PETAL DANCE ",
      "THUNDERBOLT ", "SLAM        ", "SURF        ", "THUNDER     ",
      "DARK PULSE  ", "SHADOW BALL ", "PSYCHIC     ", "PLAY ROUGH  ",
      "FLASH CANNON", "BUG BUZZ    ", "FIRE BLAST  ", "ROCK SLIDE  ",
      "DRAGON PULSE", "BLIZZARD    "
   };

   // fixed labels
   localparam logic [0:enemy_len-1][7:0]    enemy_text    = "ENEMY ";
   localparam logic [0:used_len-1][7:0]     used_text     = "USED ";
   localparam logic [0:hp_label_len-1][7:0] hp_label_text = "HP";

endpackage

// ==== design/text_field_locator.sv ====
module text_field_locator #(
   parameter battle_text_pkg::coord_t origin_x  = '0,
   parameter battle_text_pkg::coord_t origin_y  = '0,
   parameter int                      num_chars = 1
) (
   input  battle_text_pkg::coord_t      draw_x,
   input  battle_text_pkg::coord_t      draw_y,
   output logic                         hit,
   output battle_text_pkg::char_index_t char_index,
   output battle_text_pkg::glyph_col_t  glyph_col,
   output battle_text_pkg::glyph_row_t  glyph_row
);
   import battle_text_pkg::*;

   // exclusive right and bottom edges
   localparam coord_t x_end = coord_t'(origin_x + cell_w * num_chars);
   localparam coord_t y_end = coord_t'(origin_y + cell_h);

   // pixel offset from the field corner
   coord_t rel_x;
   coord_t rel_y;
   logic   in_x;
   logic   in_y;

   assign rel_x = draw_x - origin_x;
   assign rel_y = draw_y - origin_y;

   // one text row, num_chars cells wide
   assign in_x = (draw_x >= origin_x) && (draw_x < x_end);
   assign in_y = (draw_y >= origin_y) && (draw_y < y_end);

   always_comb begin
      if (in_x && in_y) begin
         hit        = 1'b1;
         // cell number, then position inside the cell
         char_index = char_index_t'(rel_x / cell_w);
         glyph_col  = glyph_col_t'(rel_x % cell_w);
         glyph_row  = glyph_row_t'(rel_y % cell_h);
      end else begin
         // outside the field everything is zero
         hit        = 1'b0;
         char_index = '0;
         glyph_col  = '0;
         glyph_row  = '0;
      end
   end

endmodule

// ==== design/field_arbiter.sv ====
module field_arbiter (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic                                pix_valid,
   output logic                                pix_ready,
   input  logic [battle_text_pkg::field_count-1:0] hit,
   input  battle_text_pkg::char_index_t        char_index [battle_text_pkg::field_count],
   input  battle_text_pkg::glyph_col_t         glyph_col  [battle_text_pkg::field_count],
   input  battle_text_pkg::glyph_row_t         glyph_row  [battle_text_pkg::field_count],
   output logic                                s1_valid,
   input  logic                                s1_ready,
   output logic                                s1_hit,
   output battle_text_pkg::field_id_t          s1_field,
   output battle_text_pkg::char_index_t        s1_index,
   output battle_text_pkg::glyph_col_t         s1_col,
   output battle_text_pkg::glyph_row_t         s1_row
);
   import battle_text_pkg::*;

   // winner of this pixel
   logic        sel_hit;
   field_id_t   sel_field;
   char_index_t sel_index;
   glyph_col_t  sel_col;
   glyph_row_t  sel_row;
   logic        load;

   // fixed priority, lowest field number wins
   always_comb begin
      sel_hit   = 1'b0;
      sel_field = '0;
      sel_index = '0;
      sel_col   = '0;
      sel_row   = '0;
      // walk down so the last match is the lowest number
      for (int i = field_count - 1; i >= 0; i--) begin
         if (hit[i]) begin
            sel_hit   = 1'b1;
            sel_field = field_id_t'(i);
            sel_index = char_index[i];
            sel_col   = glyph_col[i];
            sel_row   = glyph_row[i];
         end
      end
   end

   // stage 1 takes a pixel when empty or draining
   assign pix_ready = !s1_valid || s1_ready;
   assign load      = pix_valid && pix_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid <= 1'b0;
      end else if (pix_ready) begin
         s1_valid <= pix_valid;
      end
   end

   // grant and cell position
   always_ff @(posedge clk) begin
      if (load) begin
         s1_hit   <= sel_hit;
         s1_field <= sel_field;
         s1_index <= sel_index;
         s1_col   <= sel_col;
         s1_row   <= sel_row;
      end
   end

endmodule

// ==== design/hp_digits.sv ====
module hp_digits (
   input  battle_text_pkg::hp_t   cur_hp,
   input  battle_text_pkg::hp_t   max_hp,
   output battle_text_pkg::char_t hp_chars [battle_text_pkg::hp_value_len]
);
   import battle_text_pkg::*;

   // hundreds flags, values stay below 200
   logic cur_hund;
   logic max_hund;
   // remainder below 100
   hp_t  cur_low;
   hp_t  max_low;
   // tens digit as a number
   hp_t  cur_tens;
   hp_t  max_tens;

   assign cur_hund = cur_hp >= 8'd100;
   assign max_hund = max_hp >= 8'd100;
   assign cur_low  = cur_hund ? cur_hp - 8'd100 : cur_hp;
   assign max_low  = max_hund ? max_hp - 8'd100 : max_hp;
   assign cur_tens = hp_t'(cur_low / 10);
   assign max_tens = hp_t'(max_low / 10);

   // current value, leading zero tens blanked
   assign hp_chars[0] = cur_hund ? char_one : char_space;
   assign hp_chars[1] = (!cur_hund && cur_tens == 8'd0) ? char_space
                                                          : char_t'(char_zero + cur_tens);
   assign hp_chars[2] = char_t'(char_zero + hp_t'(cur_low % 10));

   // separator
   assign hp_chars[3] = char_slash;

   // maximum value, tens always shown
   assign hp_chars[4] = max_hund ? char_one : char_space;
   assign hp_chars[5] = char_t'(char_zero + max_tens);
   assign hp_chars[6] = char_t'(char_zero + hp_t'(max_low % 10));

endmodule

// ==== design/char_fetch.sv ====
module char_fetch (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         s1_valid,
   output logic                         s1_ready,
   input  logic                         s1_hit,
   input  battle_text_pkg::field_id_t   s1_field,
   input  battle_text_pkg::char_index_t s1_index,
   input  battle_text_pkg::glyph_col_t  s1_col,
   input  battle_text_pkg::glyph_row_t  s1_row,
   input  battle_text_pkg::poke_id_t    poke_id,
   input  battle_text_pkg::move_id_t    move_id,
   input  battle_text_pkg::char_t       hp_chars [battle_text_pkg::hp_value_len],
   input  logic                         out_ready,
   output logic                         out_valid,
   output logic                         text_hit,
   output battle_text_pkg::field_id_t   field_id,
   output battle_text_pkg::char_t       char_code,
   output battle_text_pkg::glyph_col_t  glyph_col,
   output battle_text_pkg::glyph_row_t  glyph_row
);
   import battle_text_pkg::*;

   char_t char_sel;
   logic  load;

   // character lookup for the granted field
   always_comb begin
      char_sel = char_space;
      if (s1_hit) begin
         case (s1_field)
            fld_name: begin
               char_sel = name_table[poke_id][s1_index];
            end
            fld_move: begin
               // unknown move shows blanks
               if (int'(move_id) < move_count) begin
                  char_sel = move_table[move_id][s1_index];
               end
            end
            // short fields only need the low index bits
            fld_enemy: begin
               char_sel = enemy_text[s1_index[2:0]];
            end
            fld_used: begin
               char_sel = used_text[s1_index[2:0]];
            end
            fld_hp_label: begin
               char_sel = hp_label_text[s1_index[0]];
            end
            fld_hp_value: begin
               char_sel = hp_chars[s1_index[2:0]];
            end
            default: begin
               char_sel = char_space;
            end
         endcase
      end
   end

   // output stage frees up when empty or consumed
   assign s1_ready = !out_valid || out_ready;
   assign load     = s1_valid && s1_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (s1_ready) begin
         out_valid <= s1_valid;
      end
   end

   // output word, held while out_ready is low
   always_ff @(posedge clk) begin
      if (load) begin
         text_hit  <= s1_hit;
         field_id  <= s1_field;
         char_code <= char_sel;
         glyph_col <= s1_col;
         glyph_row <= s1_row;
      end
   end

endmodule

// ==== design/battle_text_overlay.sv ====
module battle_text_overlay (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        pix_valid,
   output logic                        pix_ready,
   input  battle_text_pkg::coord_t     draw_x,
   input  battle_text_pkg::coord_t     draw_y,
   input  battle_text_pkg::poke_id_t   poke_id,
   input  battle_text_pkg::move_id_t   move_id,
   input  battle_text_pkg::hp_t        cur_hp,
   input  battle_text_pkg::hp_t        max_hp,
   output logic                        out_valid,
   input  logic                        out_ready,
   output logic                        text_hit,
   output battle_text_pkg::field_id_t  field_id,
   output battle_text_pkg::char_t      char_code,
   output battle_text_pkg::glyph_col_t glyph_col,
   output battle_text_pkg::glyph_row_t glyph_row
);
   import battle_text_pkg::*;

   // per field locator results
   logic [field_count-1:0] hit;
   char_index_t            loc_index [field_count];
   glyph_col_t             loc_col   [field_count];
   glyph_row_t             loc_row   [field_count];

   // stage 1 to stage 2
   logic                   s1_valid;
   logic                   s1_ready;
   logic                   s1_hit;
   field_id_t              s1_field;
   char_index_t            s1_index;
   glyph_col_t             s1_col;
   glyph_row_t             s1_row;

   // formatted hit points
   char_t                  hp_chars [hp_value_len];

   // creature name
   text_field_locator #(.origin_x(name_x), .origin_y(name_y), .num_chars(name_len)) u_loc_name (
      .draw_x, .draw_y, .hit(hit[fld_name]), .char_index(loc_index[fld_name]),
      .glyph_col(loc_col[fld_name]), .glyph_row(loc_row[fld_name])
   );

   // move name
   text_field_locator #(.origin_x(move_x), .origin_y(move_y), .num_chars(move_len)) u_loc_move (
      .draw_x, .draw_y, .hit(hit[fld_move]), .char_index(loc_index[fld_move]),
      .glyph_col(loc_col[fld_move]), .glyph_row(loc_row[fld_move])
   );

   // label ENEMY
   text_field_locator #(.origin_x(enemy_x), .origin_y(enemy_y), .num_chars(enemy_len))
   u_loc_enemy (
      .draw_x, .draw_y, .hit(hit[fld_enemy]), .char_index(loc_index[fld_enemy]),
      .glyph_col(loc_col[fld_enemy]), .glyph_row(loc_row[fld_enemy])
   );

   // label USED
   text_field_locator #(.origin_x(used_x), .origin_y(used_y), .num_chars(used_len)) u_loc_used (
      .draw_x, .draw_y, .hit(hit[fld_used]), .char_index(loc_index[fld_used]),
      .glyph_col(loc_col[fld_used]), .glyph_row(loc_row[fld_used])
   );

   // label HP
   text_field_locator #(.origin_x(hp_label_x), .origin_y(hp_label_y), .num_chars(hp_label_len))
   u_loc_hp_label (
      .draw_x, .draw_y, .hit(hit[fld_hp_label]), .char_index(loc_index[fld_hp_label]),
      .glyph_col(loc_col[fld_hp_label]), .glyph_row(loc_row[fld_hp_label])
   );

   // readout cur/max
   text_field_locator #(.origin_x(hp_value_x), .origin_y(hp_value_y), .num_chars(hp_value_len))
   u_loc_hp_value (
      .draw_x, .draw_y, .hit(hit[fld_hp_value]), .char_index(loc_index[fld_hp_value]),
      .glyph_col(loc_col[fld_hp_value]), .glyph_row(loc_row[fld_hp_value])
   );

   // stage 1, grant and register
   field_arbiter u_arbiter (
      .clk, .arst_n, .pix_valid, .pix_ready, .hit,
      .char_index(loc_index), .glyph_col(loc_col), .glyph_row(loc_row),
      .s1_valid, .s1_ready, .s1_hit, .s1_field, .s1_index, .s1_col, .s1_row
   );

   hp_digits u_hp_digits (
      .cur_hp, .max_hp, .hp_chars
   );

   // stage 2, character lookup and output register
   char_fetch u_fetch (
      .clk, .arst_n, .s1_valid, .s1_ready, .s1_hit, .s1_field, .s1_index, .s1_col, .s1_row,
      .poke_id, .move_id, .hp_chars, .out_ready, .out_valid,
      .text_hit, .field_id, .char_code, .glyph_col, .glyph_row
   );

endmodule

// ==== tests/tb_battle_text.sv ====
module tb_battle_text;
   timeunit 1ns;
   timeprecision 100ps;
   import battle_text_pkg::*;

   logic        clk;
   logic        arst_n;
   logic        pix_valid;
   logic        pix_ready;
   coord_t      draw_x;
   coord_t      draw_y;
   poke_id_t    poke_id;
   move_id_t    move_id;
   hp_t         cur_hp;
   hp_t         max_hp;
   logic        out_valid;
   logic        out_ready;
   logic        text_hit;
   field_id_t   field_id;
   char_t       char_code;
   glyph_col_t  glyph_col;
   glyph_row_t  glyph_row;

   // field layout indexed by field number
   localparam int fld_x [field_count] = '{int'(name_x), int'(move_x), int'(enemy_x),
                                          int'(used_x), int'(hp_label_x), int'(hp_value_x)};
   localparam int fld_y [field_count] = '{int'(name_y), int'(move_y), int'(enemy_y),
                                          int'(used_y), int'(hp_label_y), int'(hp_value_y)};
   localparam int fld_len [field_count] = '{name_len, move_len, enemy_len,
                                            used_len, hp_label_len, hp_value_len};

   int          seed = 32'h4851;
   string       test_name;
   // expected words {hit, field, char, col, row} of accepted pixels
   logic [18:0] exp_q [$];
   logic        accepted;
   logic        consumed;
   logic        held_valid;
   logic [18:0] held_word;
   int          cycle_count;
   int          last_accept;
   int          last_output;

   battle_text_overlay dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stop_with_error(string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1, "stopped at %0t", $time);
   endtask

   task automatic check(string what, int expected, int actual);
      if (expected != actual) begin
         $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
         stop_with_error("value mismatch");
      end
   endtask

   function automatic int rand_below(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // hp readout with hundreds as '1' or blank and current tens blanked under ten
   function automatic char_t hp_char(int cur, int mx, int pos);
      int v;
      int tens;
      v    = (pos < 3) ? cur : mx;
      tens = (v / 10) % 10;
      case (pos)
         0, 4: return (v >= 100) ? char_one : char_space;
         1: return (v < 100 && tens == 0) ? char_space : char_t'(char_zero + tens);
         5: return char_t'(char_zero + tens);
         3: return char_slash;
         default: return char_t'(char_zero + v % 10);
      endcase
   endfunction

   function automatic char_t text_char(int f, int idx);
      case (field_id_t'(f))
         fld_name:     return name_table[poke_id][idx];
         fld_move:     return move_table[move_id][idx];
         fld_enemy:    return enemy_text[idx];
         fld_used:     return used_text[idx];
         fld_hp_label: return hp_label_text[idx];
         default:      return hp_char(int'(cur_hp), int'(max_hp), idx);
      endcase
   endfunction

   // reference model where the first field in priority order wins
   function automatic logic [18:0] expect_word(int x, int y);
      int idx;
      int col;
      int row;
      for (int f = 0; f < field_count; f++) begin
         if (x >= fld_x[f] && x < fld_x[f] + cell_w * fld_len[f] &&
             y >= fld_y[f] && y < fld_y[f] + cell_h) begin
            idx = (x - fld_x[f]) / cell_w;
            col = (x - fld_x[f]) % cell_w;
            row = (y - fld_y[f]) % cell_h;
            return {1'b1, field_id_t'(f), text_char(f, idx), glyph_col_t'(col),
                    glyph_row_t'(row)};
         end
      end
      return {1'b0, 3'd0, char_space, 3'd0, 4'd0};
   endfunction

   // one clock cycle called on the falling edge after inputs are driven
   task automatic step();
      logic [18:0] word;
      logic [18:0] expected;
      #1;
      word = {text_hit, field_id, char_code, glyph_col, glyph_row};
      // a stalled output must not move
      if (held_valid) begin
         check("out_valid held", 1, int'(out_valid));
         check("held word", int'(held_word), int'(word));
      end
      held_valid = out_valid && !out_ready;
      held_word  = word;
      accepted   = pix_valid && pix_ready;
      consumed   = out_valid && out_ready;
      if (accepted) begin
         exp_q.push_back(expect_word(int'(draw_x), int'(draw_y)));
         last_accept = cycle_count;
      end
      if (consumed) begin
         if (exp_q.size() == 0) begin
            stop_with_error("an output arrived with no pixel outstanding");
         end else begin
            expected = exp_q.pop_front();
            check("text_hit", int'(expected[18]), int'(text_hit));
            check("field_id", int'(expected[17:15]), int'(field_id));
            check("char_code", int'(expected[14:7]), int'(char_code));
            check("glyph_col", int'(expected[6:4]), int'(glyph_col));
            check("glyph_row", int'(expected[3:0]), int'(glyph_row));
            last_output = cycle_count;
         end
      end
      cycle_count++;
      @(negedge clk);
   endtask

   task automatic send_pixel(int x, int y);
      int waited;
      waited    = 0;
      draw_x    = coord_t'(x);
      draw_y    = coord_t'(y);
      pix_valid = 1'b1;
      step();
      while (!accepted) begin
         if (waited > 50) begin
            stop_with_error("pix_ready never went high");
         end else begin
            waited++;
            step();
         end
      end
      pix_valid = 1'b0;
   endtask

   // empty the pipeline before frame attributes change
   task automatic drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         if (waited > 50) begin
            stop_with_error("out_valid never arrived for an outstanding pixel");
         end else begin
            waited++;
            step();
         end
      end
   endtask

   task automatic send_miss(int x, int y);
      check("model miss", int'({1'b0, 3'd0, char_space, 7'd0}), int'(expect_word(x, y)));
      send_pixel(x, y);
   endtask

   task automatic test_reset();
      test_name = "reset";
      #1;
      check("out_valid", 0, int'(out_valid));
      check("pix_ready", 1, int'(pix_ready));
      @(negedge clk);
      // labels ENEMY, USED and HP with varied offsets inside each cell
      for (int f = int'(fld_enemy); f <= int'(fld_hp_label); f++) begin
         for (int c = 0; c < fld_len[f]; c++) begin
            send_pixel(fld_x[f] + c * cell_w + (c * 3) % cell_w,
                       fld_y[f] + (c * 5 + 2) % cell_h);
         end
      end
      drain();
   endtask

   task automatic test_tables();
      test_name = "tables";
      for (int p = 0; p < name_count; p++) begin
         poke_id = poke_id_t'(p);
         for (int c = 0; c < name_len; c++) begin
            send_pixel(name_x + c * cell_w + c % cell_w, name_y + c);
         end
         drain();
      end
      repeat (20) begin
         move_id = move_id_t'(rand_below(move_count));
         for (int c = 0; c < move_len; c++) begin
            send_pixel(move_x + c * cell_w + (7 - c % cell_w), move_y + 15 - c);
         end
         drain();
      end
   endtask

   task automatic hp_case(int cur, int mx, logic [0:6][7:0] text);
      cur_hp = hp_t'(cur);
      max_hp = hp_t'(mx);
      for (int i = 0; i < hp_value_len; i++) begin
         check("hp reference", int'(text[i]), int'(hp_char(cur, mx, i)));
         send_pixel(hp_value_x + i * cell_w + 4, hp_value_y + 7);
      end
      drain();
   endtask

   task automatic test_hp();
      test_name = "hp";
      hp_case(5, 50, "  5/ 50");
      hp_case(37, 100, " 37/100");
      hp_case(100, 100, "100/100");
      hp_case(0, 9, "  0/ 09");
   endtask

   task automatic test_outside();
      test_name = "outside";
      for (int f = 0; f < field_count; f++) begin
         send_miss(fld_x[f], fld_y[f] + cell_h);
         // ENEMY and USED end where the name and move fields begin
         if (f == int'(fld_enemy) || f == int'(fld_used)) begin
            send_pixel(fld_x[f] + cell_w * fld_len[f], fld_y[f]);
         end else begin
            send_miss(fld_x[f] + cell_w * fld_len[f], fld_y[f]);
         end
      end
      send_miss(0, 0);
      send_miss(639, 479);
      send_miss(31, 16);
      send_miss(32, 15);
      drain();
   endtask

   task automatic test_timing();
      test_name = "latency";
      out_ready = 1'b1;
      send_pixel(100, 20);
      drain();
      check("edges to output", 2, last_output - last_accept);
   endtask

   task automatic test_stream();
      int sent;
      int waited;
      int f;
      test_name  = "stream";
      sent       = 0;
      waited     = 0;
      poke_id    = poke_id_t'(rand_below(name_count));
      move_id    = move_id_t'(rand_below(move_count));
      cur_hp     = hp_t'(rand_below(200));
      max_hp     = hp_t'(rand_below(200));
      while (sent < 200 || exp_q.size() != 0) begin
         if (waited > 5000) begin
            stop_with_error("stream stalled, pixels or outputs stopped moving");
         end else begin
            waited++;
            out_ready = (rand_below(3) != 0);
            if (!pix_valid && sent < 200) begin
               f = rand_below(field_count);
               // mostly around a field and sometimes anywhere on screen
               if (rand_below(4) == 0) begin
                  draw_x = coord_t'(rand_below(640));
                  draw_y = coord_t'(rand_below(480));
               end else begin
                  draw_x = coord_t'(fld_x[f] - 4 + rand_below(cell_w * fld_len[f] + 8));
                  draw_y = coord_t'(fld_y[f] - 2 + rand_below(cell_h + 4));
               end
               pix_valid = 1'b1;
            end
            step();
            if (accepted) begin
               sent++;
               pix_valid = 1'b0;
            end
         end
      end
      out_ready = 1'b1;
      // an idle pipeline stays empty with no repeated output
      repeat (4) begin
         step();
         check("out_valid after drain", 0, int'(out_valid));
         check("pix_ready after drain", 1, int'(pix_ready));
      end
   endtask

   initial begin
      arst_n       = 1'b0;
      pix_valid    = 1'b0;
      draw_x       = '0;
      draw_y       = '0;
      poke_id      = '0;
      move_id      = '0;
      cur_hp       = '0;
      max_hp       = '0;
      out_ready    = 1'b1;
      held_valid   = 1'b0;
      held_word    = '0;
      cycle_count  = 0;
      last_accept  = 0;
      last_output  = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      test_reset();
      test_tables();
      test_hp();
      test_outside();
      test_timing();
      test_stream();
      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== sources.f ====
design/battle_text_pkg.sv
design/text_field_locator.sv
design/field_arbiter.sv
design/hp_digits.sv
design/char_fetch.sv
design/battle_text_overlay.sv
tests/tb_battle_text.sv

// ==== Makefile ====
# Verilator simulation of the battle screen text overlay

TOP := tb_battle_text
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove obj_dir and the log"
	@echo "  help   show this list"

# the run may stop with an error, the log decides the result
test:
	verilator --binary --timing --top-module $(TOP) -f sources.f -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > $(LOG) 2>&1
	@if grep -q "TB PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
